/* include/ex_config.svh */
// execute stage sizing

`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// data path width
`define EX_XLEN 32

// reorder buffer tag width
`define EX_TAG_W 5

// number of alu issue lanes
`define EX_NUM_LANES 2

`endif

/* logic/isa_pkg.sv */
// rv32 integer encodings

`default_nettype none

package isa_pkg;

    ////////////////////////////////////////
    // alu and operand select codes
    ////////////////////////////////////////

    typedef enum logic [4:0] {
        ALU_ADD  = 5'h00,
        ALU_SUB  = 5'h01,
        ALU_SLT  = 5'h02,
        ALU_SLTU = 5'h03,
        ALU_AND  = 5'h04,
        ALU_OR   = 5'h05,
        ALU_XOR  = 5'h06,
        ALU_SLL  = 5'h07,
        ALU_SRL  = 5'h08,
        ALU_SRA  = 5'h09
    } alu_func_t;

    // a side source
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_NPC  = 2'h1,
        OPA_IS_PC   = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_sel_t;

    // b side source
    typedef enum logic [3:0] {
        OPB_IS_RS2   = 4'h0,
        OPB_IS_I_IMM = 4'h1,
        OPB_IS_S_IMM = 4'h2,
        OPB_IS_B_IMM = 4'h3,
        OPB_IS_U_IMM = 4'h4,
        OPB_IS_J_IMM = 4'h5
    } opb_sel_t;

    // branch funct3 values
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_func_t;

    ////////////////////////////////////////
    // immediate extraction
    ////////////////////////////////////////

    function automatic logic [31:0] i_imm(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    // store offset split around rd field
    function automatic logic [31:0] s_imm(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    // branch offset, bit 0 always zero
    function automatic logic [31:0] b_imm(input logic [31:0] inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] u_imm(input logic [31:0] inst);
        return {inst[31:12], 12'h000};
    endfunction

    // jal offset, scrambled field order
    function automatic logic [31:0] j_imm(input logic [31:0] inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire

/* logic/ex_pkg.sv */
// execute stage packets

`default_nettype none

`include "ex_config.svh"

package ex_pkg;

    ////////////////////////////////////////
    // issue side
    ////////////////////////////////////////

    // one lane as handed over by the issue logic
    typedef struct packed {
        logic                      valid;
        logic [`EX_TAG_W-1:0]      rob_tag;
        logic [`EX_XLEN-1:0]       pc;
        logic [`EX_XLEN-1:0]       npc;
        logic [31:0]               inst;
        // register file values
        logic [`EX_XLEN-1:0]       opa;
        logic [`EX_XLEN-1:0]       opb;
        isa_pkg::opa_sel_t         opa_sel;
        isa_pkg::opb_sel_t         opb_sel;
        isa_pkg::alu_func_t        alu_func;
        logic                      cond_branch;
        logic                      uncond_branch;
    } issue_pkt_t;

    // operands resolved, ready for the alu
    typedef struct packed {
        logic                      valid;
        logic [`EX_TAG_W-1:0]      rob_tag;
        logic [`EX_XLEN-1:0]       opa_val;
        logic [`EX_XLEN-1:0]       opb_val;
        isa_pkg::alu_func_t        alu_func;
        isa_pkg::br_func_t         br_func;
        // raw register values for the compare
        logic [`EX_XLEN-1:0]       rs1;
        logic [`EX_XLEN-1:0]       rs2;
        logic                      cond_branch;
        logic                      uncond_branch;
        logic [`EX_XLEN-1:0]       npc;
    } lane_op_t;

    ////////////////////////////////////////
    // completion side
    ////////////////////////////////////////

    typedef struct packed {
        logic                      valid;
        logic [`EX_TAG_W-1:0]      rob_tag;
        logic [`EX_XLEN-1:0]       value;
        logic                      take_branch;
    } lane_res_t;

    // what goes out on the cdb
    typedef struct packed {
        logic                      valid;
        logic [`EX_TAG_W-1:0]      rob_tag;
        logic [`EX_XLEN-1:0]       value;
        logic                      take_branch;
    } cp_pkt_t;

endpackage

`default_nettype wire

/* logic/operand_select.sv */
// lane operand multiplexers

`default_nettype none

`include "ex_config.svh"

module operand_select (
    input  ex_pkg::issue_pkt_t [`EX_NUM_LANES-1:0] issue_pkt,
    output ex_pkg::lane_op_t   [`EX_NUM_LANES-1:0] lane_op
);
    import isa_pkg::*;

    // same mux pair for every lane, so one loop covers them all
    always_comb begin
        for (int i = 0; i < `EX_NUM_LANES; i++) begin
            ////////////////////////////////////////
            // a operand
            ////////////////////////////////////////
            case (issue_pkt[i].opa_sel)
                OPA_IS_RS1:  lane_op[i].opa_val = issue_pkt[i].opa;
                OPA_IS_NPC:  lane_op[i].opa_val = issue_pkt[i].npc;
                OPA_IS_PC:   lane_op[i].opa_val = issue_pkt[i].pc;
                OPA_IS_ZERO: lane_op[i].opa_val = '0;
                // filler so a bad select is easy to spot
                default:     lane_op[i].opa_val = `EX_XLEN'hdeadface;
            endcase

            ////////////////////////////////////////
            // b operand
            ////////////////////////////////////////
            case (issue_pkt[i].opb_sel)
                OPB_IS_RS2: begin
                    lane_op[i].opb_val = issue_pkt[i].opb;
                end
                OPB_IS_I_IMM: begin
                    lane_op[i].opb_val = i_imm(issue_pkt[i].inst);
                end
                OPB_IS_S_IMM: begin
                    lane_op[i].opb_val = s_imm(issue_pkt[i].inst);
                end
                // branch target offset
                OPB_IS_B_IMM: begin
                    lane_op[i].opb_val = b_imm(issue_pkt[i].inst);
                end
                OPB_IS_U_IMM: begin
                    lane_op[i].opb_val = u_imm(issue_pkt[i].inst);
                end
                // jal target offset
                OPB_IS_J_IMM: begin
                    lane_op[i].opb_val = j_imm(issue_pkt[i].inst);
                end
                default: begin
                    lane_op[i].opb_val = `EX_XLEN'hfacefeed;
                end
            endcase

            // compare code sits in funct3
            lane_op[i].br_func       = br_func_t'(issue_pkt[i].inst[14:12]);

            // compare always works on the register values
            lane_op[i].rs1           = issue_pkt[i].opa;
            lane_op[i].rs2           = issue_pkt[i].opb;

            // control and bookkeeping pass along
            lane_op[i].valid         = issue_pkt[i].valid;
            lane_op[i].rob_tag       = issue_pkt[i].rob_tag;
            lane_op[i].alu_func      = issue_pkt[i].alu_func;
            lane_op[i].cond_branch   = issue_pkt[i].cond_branch;
            lane_op[i].uncond_branch = issue_pkt[i].uncond_branch;
            lane_op[i].npc           = issue_pkt[i].npc;
        end
    end

endmodule

`default_nettype wire

/* logic/exec_lane.sv */
// single alu lane with branch resolve

`default_nettype none

`include "ex_config.svh"

module exec_lane (
    input  ex_pkg::lane_op_t  lane_op,
    output ex_pkg::lane_res_t lane_res
);
    import isa_pkg::*;

    // signed views for slt, sra and branch compares
    logic signed [`EX_XLEN-1:0] opa_s;
    logic signed [`EX_XLEN-1:0] opb_s;
    logic signed [`EX_XLEN-1:0] rs1_s;
    logic signed [`EX_XLEN-1:0] rs2_s;

    // shift amount, low five bits of b
    logic [4:0]                 shamt;

    logic [`EX_XLEN-1:0]        alu_result;
    logic                       cmp_true;
    logic                       take;

    assign opa_s = lane_op.opa_val;
    assign opb_s = lane_op.opb_val;
    assign rs1_s = lane_op.rs1;
    assign rs2_s = lane_op.rs2;
    assign shamt = lane_op.opb_val[4:0];

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////

    always_comb begin
        case (lane_op.alu_func)
            ALU_ADD:  alu_result = lane_op.opa_val + lane_op.opb_val;
            ALU_SUB:  alu_result = lane_op.opa_val - lane_op.opb_val;
            ALU_SLT:  alu_result = `EX_XLEN'(opa_s < opb_s);
            ALU_SLTU: alu_result = `EX_XLEN'(lane_op.opa_val < lane_op.opb_val);
            ALU_AND:  alu_result = lane_op.opa_val & lane_op.opb_val;
            ALU_OR:   alu_result = lane_op.opa_val | lane_op.opb_val;
            ALU_XOR:  alu_result = lane_op.opa_val ^ lane_op.opb_val;
            ALU_SLL:  alu_result = lane_op.opa_val << shamt;
            ALU_SRL:  alu_result = lane_op.opa_val >> shamt;
            // sign bit fills from the left
            ALU_SRA:  alu_result = opa_s >>> shamt;
            // unused codes
            default:  alu_result = `EX_XLEN'hfacebeec;
        endcase
    end

    ////////////////////////////////////////
    // branch compare
    ////////////////////////////////////////

    always_comb begin
        case (lane_op.br_func)
            BR_EQ:   cmp_true = (lane_op.rs1 == lane_op.rs2);
            BR_NE:   cmp_true = (lane_op.rs1 != lane_op.rs2);
            BR_LT:   cmp_true = (rs1_s < rs2_s);
            BR_GE:   cmp_true = (rs1_s >= rs2_s);
            BR_LTU:  cmp_true = (lane_op.rs1 < lane_op.rs2);
            BR_GEU:  cmp_true = (lane_op.rs1 >= lane_op.rs2);
            // funct3 010 and 011 are not branches
            default: cmp_true = 1'b0;
        endcase
    end

    // jumps always go, conditionals only on a true compare
    assign take = lane_op.uncond_branch || (lane_op.cond_branch && cmp_true);

    ////////////////////////////////////////
    // lane result
    ////////////////////////////////////////

    assign lane_res.valid       = lane_op.valid;
    assign lane_res.rob_tag     = lane_op.rob_tag;
    assign lane_res.take_branch = take;

    // fall through to npc on a not taken conditional branch
    assign lane_res.value = (lane_op.cond_branch && !take) ? lane_op.npc : alu_result;

endmodule

`default_nettype wire

/* logic/completion_arbiter.sv */
// cdb completion arbiter

`default_nettype none

`include "ex_config.svh"

module completion_arbiter (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  cdb_busy,
    input  ex_pkg::lane_res_t [`EX_NUM_LANES-1:0] lane_res,
    output ex_pkg::cp_pkt_t                       cp_pkt
);
    import ex_pkg::*;

    // winner this cycle when the bus is free
    cp_pkt_t win_pkt;

    // last cycle's cp_pkt, replayed under busy
    cp_pkt_t held_pkt;

    ////////////////////////////////////////
    // priority pick
    ////////////////////////////////////////

    // walk from the top lane down
    // lower lanes overwrite, so lane 0 wins
    always_comb begin
        win_pkt = '0;
        for (int i = `EX_NUM_LANES - 1; i >= 0; i--) begin
            if (lane_res[i].valid) begin
                win_pkt.valid       = 1'b1;
                win_pkt.rob_tag     = lane_res[i].rob_tag;
                win_pkt.value       = lane_res[i].value;
                win_pkt.take_branch = lane_res[i].take_branch;
            end
        end
    end

    ////////////////////////////////////////
    // output and hold
    ////////////////////////////////////////

    // new result goes out the same cycle unless the bus stalls
    assign cp_pkt = cdb_busy ? held_pkt : win_pkt;

    // captures every cycle
    // under busy it just reloads itself
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_pkt <= '0;
        end else begin
            held_pkt <= cp_pkt;
        end
    end

endmodule

`default_nettype wire

/* logic/stage_ex.sv */
// integer execute stage

`default_nettype none

`include "ex_config.svh"

module stage_ex (
    input  logic                                   clk,
    input  logic                                   rst,
    input  ex_pkg::issue_pkt_t [`EX_NUM_LANES-1:0] issue_pkt,
    input  logic                                   cdb_busy,
    output ex_pkg::cp_pkt_t                        cp_pkt
);
    import ex_pkg::*;

    // resolved operands per lane
    lane_op_t  [`EX_NUM_LANES-1:0] lane_op;

    // per lane results into the arbiter
    lane_res_t [`EX_NUM_LANES-1:0] lane_res;

    ////////////////////////////////////////
    // operand muxes
    ////////////////////////////////////////

    operand_select u_operand_select (
        .issue_pkt (issue_pkt),
        .lane_op   (lane_op)
    );

    ////////////////////////////////////////
    // alu lanes
    ////////////////////////////////////////

    for (genvar g = 0; g < `EX_NUM_LANES; g++) begin : g_lane
        exec_lane u_exec_lane (
            .lane_op  (lane_op[g]),
            .lane_res (lane_res[g])
        );
    end

    // single cdb port, lane 0 first
    completion_arbiter u_completion_arbiter (
        .clk      (clk),
        .rst      (rst),
        .cdb_busy (cdb_busy),
        .lane_res (lane_res),
        .cp_pkt   (cp_pkt)
    );

endmodule

`default_nettype wire

/* tb/stage_ex_assert.sv */
// execute stage checkers

`default_nettype none

`include "ex_config.svh"

module stage_ex_assert (
    input logic                                   clk,
    input logic                                   rst,
    input ex_pkg::issue_pkt_t [`EX_NUM_LANES-1:0] issue_pkt,
    input logic                                   cdb_busy,
    input ex_pkg::cp_pkt_t                        cp_pkt
);
    import isa_pkg::*;
    import ex_pkg::*;

    // failures seen so far, read by the testbench at the end
    int fail_cnt = 0;

    cp_pkt_t exp_pkt;
    cp_pkt_t model_out;
    cp_pkt_t model_prev;
    logic    any_valid;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic cp_pkt_t predict(input issue_pkt_t p);
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        logic [`EX_XLEN-1:0] r;
        logic                hit;
        cp_pkt_t             c;
        case (p.opa_sel)
            OPA_IS_NPC:  a = p.npc;
            OPA_IS_PC:   a = p.pc;
            OPA_IS_ZERO: a = '0;
            default:     a = p.opa;
        endcase
        // immediates by signed resize of the gathered fields
        case (p.opb_sel)
            OPB_IS_I_IMM: b = `EX_XLEN'($signed(p.inst[31:20]));
            OPB_IS_S_IMM: b = `EX_XLEN'($signed({p.inst[31:25], p.inst[11:7]}));
            OPB_IS_B_IMM: b = `EX_XLEN'($signed({p.inst[31], p.inst[7], p.inst[30:25],
                                                   p.inst[11:8], 1'b0}));
            OPB_IS_U_IMM: b = {p.inst[31:12], 12'd0};
            OPB_IS_J_IMM: b = `EX_XLEN'($signed({p.inst[31], p.inst[19:12], p.inst[20],
                                                   p.inst[30:21], 1'b0}));
            default:      b = p.opb;
        endcase
        case (p.alu_func)
            ALU_SUB:  r = a + ~b + `EX_XLEN'd1;
            ALU_SLT:  r = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: r = {31'd0, a < b};
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLL:  r = a << b[4:0];
            ALU_SRL:  r = a >> b[4:0];
            ALU_SRA:  r = `EX_XLEN'($signed(a) >>> b[4:0]);
            default:  r = a + b;
        endcase
        // compare on raw register values, funct3 coded
        case (p.inst[14:12])
            3'b000:  hit = (p.opa == p.opb);
            3'b001:  hit = (p.opa != p.opb);
            3'b100:  hit = ($signed(p.opa) < $signed(p.opb));
            3'b101:  hit = !($signed(p.opa) < $signed(p.opb));
            3'b110:  hit = (p.opa < p.opb);
            3'b111:  hit = !(p.opa < p.opb);
            default: hit = 1'b0;
        endcase
        c = '0;
        c.valid       = p.valid;
        c.rob_tag     = p.rob_tag;
        c.take_branch = p.uncond_branch | (p.cond_branch & hit);
        c.value       = (p.cond_branch && !c.take_branch) ? p.npc : r;
        return c;
    endfunction

    // first valid lane wins
    always_comb begin
        exp_pkt   = '0;
        any_valid = 1'b0;
        for (int i = 0; i < `EX_NUM_LANES; i++) begin
            if (issue_pkt[i].valid && !any_valid) begin
                exp_pkt   = predict(issue_pkt[i]);
                any_valid = 1'b1;
            end
        end
    end

    assign model_out = cdb_busy ? model_prev : exp_pkt;

    // model copy of the hold register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            model_prev <= '0;
        end else begin
            model_prev <= model_out;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk) (rst && (cdb_busy || !any_valid)) |->
                                    !cp_pkt.valid)
        else begin
            fail_cnt++;
            $error("MISMATCH t=%0t cp_pkt.valid high in reset", $time);
        end

    a_result: assert property (@(posedge clk) disable iff (rst) cp_pkt == model_out)
        else begin
            fail_cnt++;
            $error("MISMATCH t=%0t cp_pkt %h expected %h", $time, $sampled(cp_pkt),
                   $sampled(model_out));
        end

    // frozen output under back-pressure
    a_hold: assert property (@(posedge clk) disable iff (rst)
                             cdb_busy |-> cp_pkt == $past(cp_pkt))
        else begin
            fail_cnt++;
            $error("MISMATCH t=%0t cp_pkt moved while cdb busy", $time);
        end

    a_known: assert property (@(posedge clk) !$isunknown(cp_pkt))
        else begin
            fail_cnt++;
            $error("MISMATCH t=%0t cp_pkt has unknown bits", $time);
        end

endmodule

bind stage_ex stage_ex_assert u_checker (
    .clk       (clk),
    .rst       (rst),
    .issue_pkt (issue_pkt),
    .cdb_busy  (cdb_busy),
    .cp_pkt    (cp_pkt)
);

`default_nettype wire

/* tb/tb_stage_ex.sv */
// execute stage testbench

`default_nettype none

`include "ex_config.svh"

module tb_stage_ex;
    import isa_pkg::*;
    import ex_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RAND_CYCLES = 120;
    // reset, alu, sources, branches, busy, priority, random, tail
    localparam int STIM_CYCLES = 6 + 40 + 48 + 40 + 18 + 10 + RAND_CYCLES + 3;

    logic                           clk;
    logic                           rst;
    logic                           cdb_busy;
    issue_pkt_t [`EX_NUM_LANES-1:0] issue_pkt;
    cp_pkt_t                        cp_pkt;
    int                             errors;

    stage_ex dut_i (
        .clk       (clk),
        .rst       (rst),
        .issue_pkt (issue_pkt),
        .cdb_busy  (cdb_busy),
        .cp_pkt    (cp_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #((STIM_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: stimulus did not finish within %0d cycles", STIM_CYCLES + 100);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // random valid packet, aligned pc, npc right behind it
    function automatic issue_pkt_t make_pkt(input opa_sel_t a_sel, input opb_sel_t b_sel,
                                            input alu_func_t func);
        issue_pkt_t p;
        p          = '0;
        p.valid    = 1'b1;
        p.rob_tag  = `EX_TAG_W'($urandom);
        p.pc       = $urandom & 32'hffff_fffc;
        p.npc      = p.pc + 32'd4;
        p.inst     = $urandom;
        p.opa      = $urandom;
        p.opb      = $urandom;
        p.opa_sel  = a_sel;
        p.opb_sel  = b_sel;
        p.alu_func = func;
        return p;
    endfunction

    function automatic alu_func_t rand_func();
        return alu_func_t'($urandom_range(9, 0));
    endfunction

    function automatic int rand_lane();
        return $urandom_range(`EX_NUM_LANES - 1, 0);
    endfunction

    task automatic drive_all(input issue_pkt_t [`EX_NUM_LANES-1:0] v, input logic busy);
        @(posedge clk);
        issue_pkt <= v;
        cdb_busy  <= busy;
    endtask

    // one lane valid, the rest idle
    task automatic drive_one(input int lane, input issue_pkt_t p, input logic busy);
        issue_pkt_t [`EX_NUM_LANES-1:0] v;
        v       = '0;
        v[lane] = p;
        drive_all(v, busy);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        issue_pkt_t                     p;
        issue_pkt_t [`EX_NUM_LANES-1:0] v;
        void'($urandom(57));
        rst        = 1'b1;
        cdb_busy   = 1'b1;
        issue_pkt  = '0;

        // reset, bus toggling, valid lanes only while busy
        drive_all('0, 1'b0);
        drive_one(0, make_pkt(OPA_IS_RS1, OPB_IS_RS2, ALU_ADD), 1'b1);
        drive_one(1, make_pkt(OPA_IS_RS1, OPB_IS_RS2, ALU_SUB), 1'b1);
        @(posedge clk);
        rst      <= 1'b0;
        cdb_busy <= 1'b1;
        // busy straight after reset replays the empty packet
        drive_one(0, make_pkt(OPA_IS_RS1, OPB_IS_RS2, ALU_ADD), 1'b1);
        drive_one(1, make_pkt(OPA_IS_RS1, OPB_IS_RS2, ALU_OR), 1'b1);

        // all ten alu functions on register operands
        for (int f = 0; f < 10; f++) begin
            repeat (4) begin
                drive_one(rand_lane(), make_pkt(OPA_IS_RS1, OPB_IS_RS2, alu_func_t'(f)), 1'b0);
            end
        end

        // every a and b source
        for (int a = 0; a < 4; a++) begin
            for (int b = 0; b < 6; b++) begin
                repeat (2) begin
                    p = make_pkt(opa_sel_t'(a), opb_sel_t'(b), rand_func());
                    drive_one(rand_lane(), p, 1'b0);
                end
            end
        end

        // six compares, rs1 equal, lower and higher than rs2
        for (int c = 0; c < 8; c++) begin
            if (c != 2 && c != 3) begin
                for (int k = 0; k < 6; k++) begin
                    p               = make_pkt(OPA_IS_PC, OPB_IS_B_IMM, ALU_ADD);
                    p.inst[14:12]   = 3'(c);
                    p.cond_branch   = 1'b1;
                    // small positive values order the same signed and unsigned
                    if (k % 3 == 0) begin
                        p.opb = p.opa;
                    end else if (k % 3 == 1) begin
                        p.opa = p.opa >> 2;
                        p.opb = p.opa + 32'd1;
                    end else begin
                        p.opb = p.opb >> 2;
                        p.opa = p.opb + 32'd1;
                    end
                    drive_one(rand_lane(), p, 1'b0);
                end
            end
        end
        // jal style jumps
        repeat (4) begin
            p               = make_pkt(OPA_IS_PC, OPB_IS_J_IMM, ALU_ADD);
            p.uncond_branch = 1'b1;
            drive_one(rand_lane(), p, 1'b0);
        end

        // back-pressure with changing inputs
        repeat (3) begin
            drive_one(rand_lane(), make_pkt(OPA_IS_RS1, OPB_IS_RS2, rand_func()), 1'b0);
            repeat (5) begin
                drive_one(rand_lane(), make_pkt(OPA_IS_RS1, OPB_IS_I_IMM, rand_func()), 1'b1);
            end
        end

        // every lane valid at once
        repeat (10) begin
            for (int i = 0; i < `EX_NUM_LANES; i++) begin
                v[i] = make_pkt(OPA_IS_RS1, OPB_IS_I_IMM, rand_func());
            end
            drive_all(v, 1'b0);
        end

        // random mix, busy about one cycle in four
        repeat (RAND_CYCLES) begin
            for (int i = 0; i < `EX_NUM_LANES; i++) begin
                v[i] = make_pkt(opa_sel_t'($urandom_range(3, 0)),
                                opb_sel_t'($urandom_range(5, 0)), rand_func());
                v[i].valid = 1'($urandom_range(1, 0));
            end
            drive_all(v, 1'($urandom_range(3, 0) == 0));
        end

        drive_all('0, 1'b0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        errors = dut_i.u_checker.fail_cnt;
        $display("checks finished, assertion failures: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
logic/isa_pkg.sv
logic/ex_pkg.sv
logic/operand_select.sv
logic/exec_lane.sv
logic/completion_arbiter.sv
logic/stage_ex.sv
tb/stage_ex_assert.sv
tb/tb_stage_ex.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_stage_ex
FILELIST  = compile.f
BUILD_DIR = obj_dir
RUN_ARGS  = +verilator+error+limit+10000
PASS_MSG  = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
